// File: common/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// core widths
`define MIPS_XLEN      32  // data and address width
`define MIPS_REG_AW    5   // register index width
`define MIPS_NUM_REGS  32
`define MIPS_CNT_W     32  // perf counter width
`define MIPS_RESET_PC  32'h0000_0000

`endif

// File: common/isa_pkg.sv
package isa_pkg;

    // kept opcodes, r-type is all zero
    typedef enum logic [5:0] {
        op_rtype = 6'b000_000,
        op_j     = 6'b000_010,
        op_jal   = 6'b000_011,
        op_beq   = 6'b000_100,
        op_bne   = 6'b000_101,
        op_addiu = 6'b001_001,
        op_lui   = 6'b001_111,
        op_lw    = 6'b100_011,
        op_sw    = 6'b101_011
    } opcode_t;

    // r-type function field
    typedef enum logic [5:0] {
        fn_sll  = 6'b000_000,
        fn_addu = 6'b100_001,
        fn_or   = 6'b100_101,
        fn_slt  = 6'b101_010
    } funct_t;

    typedef struct packed {
        opcode_t    opcode;  // [31:26]
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;   // [5:0]
    } instr_t;

    // i-type immediate, low 16 bits
    function automatic logic [15:0] imm16(instr_t i);
        return {i.rd, i.shamt, i.funct};
    endfunction

    // j-type word index, low 26 bits
    function automatic logic [25:0] jidx(instr_t i);
        return {i.rs, i.rt, i.rd, i.shamt, i.funct};
    endfunction

endpackage

// File: common/core_pkg.sv
package core_pkg;

`include "mips_cfg.svh"

    typedef enum logic [4:0] {
        st_fetch, st_decode,
        st_mem_addr, st_load_read, st_load_wb, st_store_write,
        st_r_exec, st_r_shift, st_r_wb,
        st_imm_exec, st_lui_exec, st_imm_wb,
        st_branch_eq, st_branch_ne,
        st_jump, st_jal_link, st_jal_jump
    } state_t;

    // sltu has no user among the kept instructions
    typedef enum logic [2:0] {
        aluop_and, aluop_or, aluop_add, aluop_sltu,
        aluop_sll, aluop_lui, aluop_sub, aluop_slt
    } alu_op_t;

    typedef enum logic [1:0] {ctl_add, ctl_sub, ctl_r_func, ctl_lui} alu_ctl_t;
    typedef enum logic [1:0] {srca_pc, srca_reg, srca_shamt} src_a_t;
    typedef enum logic [1:0] {srcb_reg, srcb_four, srcb_imm, srcb_imm_sh} src_b_t;
    typedef enum logic [1:0] {pcsrc_alu, pcsrc_alu_out, pcsrc_jump} pc_src_t;
    typedef enum logic [1:0] {dst_rt, dst_rd, dst_ra} reg_dst_t;

    typedef struct packed {
        logic     pc_write;      // unconditional
        logic     pc_write_beq;  // taken when zero
        logic     pc_write_bne;  // taken when not zero
        logic     mem_read;
        logic     mem_write;
        logic     ir_write;
        logic     reg_write;
        logic     mem_to_reg;    // 1 selects mdr
        pc_src_t  pc_src;
        alu_ctl_t alu_ctl;
        src_a_t   src_a;
        src_b_t   src_b;
        reg_dst_t reg_dst;
    } ctrl_word_t;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0] addr;
        logic [`MIPS_XLEN-1:0] wdata;
        logic                  read;
        logic                  write;
    } mem_req_t;

    typedef struct packed {
        logic [`MIPS_CNT_W-1:0] cycles;
        logic [`MIPS_CNT_W-1:0] instrs;
        logic [`MIPS_CNT_W-1:0] branches;  // branch and jump
        logic [`MIPS_CNT_W-1:0] loads;
        logic [`MIPS_CNT_W-1:0] stores;
    } perf_cnt_t;

endpackage

// File: datapath/reg_file.sv
`include "mips_cfg.svh"

module reg_file (
    input  logic                    clk,
    input  logic [`MIPS_REG_AW-1:0] raddr1,
    input  logic [`MIPS_REG_AW-1:0] raddr2,
    input  logic [`MIPS_REG_AW-1:0] waddr,
    input  logic                    we,
    input  logic [`MIPS_XLEN-1:0]   wdata,
    output logic [`MIPS_XLEN-1:0]   rdata1,
    output logic [`MIPS_XLEN-1:0]   rdata2
);

    logic [`MIPS_XLEN-1:0] regs [0:`MIPS_NUM_REGS-1];

    // r0 is never written
    always_ff @(posedge clk)
    begin
        if (we && (waddr != '0))
            regs[waddr] <= wdata;
    end

    // async reads, r0 forced to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: datapath/alu.sv
`include "mips_cfg.svh"

module alu (
    input  core_pkg::alu_ctl_t    ctl,
    input  isa_pkg::funct_t       funct,
    input  logic [`MIPS_XLEN-1:0] a,
    input  logic [`MIPS_XLEN-1:0] b,
    output logic [`MIPS_XLEN-1:0] result,
    output logic                  zero
);

    core_pkg::alu_op_t op;

    // control code and funct to operation
    always_comb
    begin
        case (ctl)
            core_pkg::ctl_sub: op = core_pkg::aluop_sub;
            core_pkg::ctl_lui: op = core_pkg::aluop_lui;
            core_pkg::ctl_r_func:
            begin
                case (funct)
                    isa_pkg::fn_or:  op = core_pkg::aluop_or;
                    isa_pkg::fn_sll: op = core_pkg::aluop_sll;
                    isa_pkg::fn_slt: op = core_pkg::aluop_slt;
                    default:         op = core_pkg::aluop_add;  // addu
                endcase
            end
            default:           op = core_pkg::aluop_add;
        endcase
    end

    always_comb
    begin
        case (op)
            core_pkg::aluop_and:  result = a & b;
            core_pkg::aluop_or:   result = a | b;
            core_pkg::aluop_sltu: result = {{(`MIPS_XLEN-1){1'b0}}, (a < b)};
            core_pkg::aluop_sll:  result = b << a[4:0];  // shamt in a
            core_pkg::aluop_lui:  result = b << 16;
            core_pkg::aluop_sub:  result = a - b;
            core_pkg::aluop_slt:  result = {{(`MIPS_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            default:              result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: datapath/datapath.sv
`include "mips_cfg.svh"

module datapath (
    input  logic                  clk,
    input  logic                  rst,
    input  core_pkg::ctrl_word_t  ctrl,
    input  logic [`MIPS_XLEN-1:0] instruction,
    input  logic [`MIPS_XLEN-1:0] read_data,
    output isa_pkg::instr_t       instr,
    output logic [`MIPS_XLEN-1:0] pc,
    output core_pkg::mem_req_t    mem
);

    isa_pkg::instr_t         ir;
    logic [`MIPS_XLEN-1:0]   mdr, a_reg, b_reg, alu_out;  // per-cycle holding regs
    logic [`MIPS_XLEN-1:0]   rdata1, rdata2, wdata;
    logic [`MIPS_REG_AW-1:0] waddr;
    logic [15:0]             imm_raw;
    logic [`MIPS_XLEN-1:0]   imm_ext, imm_sh, shamt_ext, jump_target;
    logic [`MIPS_XLEN-1:0]   alu_a, alu_b, alu_result, pc_next;
    logic                    alu_zero;
    logic                    pc_en;

    ////////////////////////////////////////////////////////////////////
    // instruction and holding registers
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
            ir <= '0;
        else if (ctrl.ir_write)
            ir <= isa_pkg::instr_t'(instruction);
    end

    always_ff @(posedge clk)
    begin
        mdr     <= read_data;   // load data, used one cycle later
        a_reg   <= rdata1;
        b_reg   <= rdata2;
        alu_out <= alu_result;
    end

    assign instr = ir;

    // immediates
    assign imm_raw     = isa_pkg::imm16(ir);
    assign imm_ext     = {{16{imm_raw[15]}}, imm_raw};
    assign imm_sh      = {imm_ext[`MIPS_XLEN-3:0], 2'b00};
    assign shamt_ext   = {{(`MIPS_XLEN-5){1'b0}}, ir.shamt};
    assign jump_target = {pc[31:28], isa_pkg::jidx(ir), 2'b00};  // pc already +4

    ////////////////////////////////////////////////////////////////////
    // register file and write-back
    ////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (ctrl.reg_dst)
            core_pkg::dst_rd: waddr = ir.rd;
            core_pkg::dst_ra: waddr = 5'd31;  // jal link
            default:          waddr = ir.rt;
        endcase
    end

    assign wdata = ctrl.mem_to_reg ? mdr : alu_out;

    reg_file u_rf (
        .clk    (clk),
        .raddr1 (ir.rs),
        .raddr2 (ir.rt),
        .waddr  (waddr),
        .we     (ctrl.reg_write),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    ////////////////////////////////////////////////////////////////////
    // alu operands
    ////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (ctrl.src_a)
            core_pkg::srca_reg:   alu_a = a_reg;
            core_pkg::srca_shamt: alu_a = shamt_ext;
            default:              alu_a = pc;
        endcase
        case (ctrl.src_b)
            core_pkg::srcb_four:   alu_b = `MIPS_XLEN'd4;
            core_pkg::srcb_imm:    alu_b = imm_ext;
            core_pkg::srcb_imm_sh: alu_b = imm_sh;
            default:               alu_b = b_reg;
        endcase
    end

    alu u_alu (
        .ctl    (ctrl.alu_ctl),
        .funct  (ir.funct),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    ////////////////////////////////////////////////////////////////////
    // pc update
    ////////////////////////////////////////////////////////////////////
    assign pc_en = ctrl.pc_write
                 | (ctrl.pc_write_beq & alu_zero)
                 | (ctrl.pc_write_bne & ~alu_zero);

    always_comb
    begin
        case (ctrl.pc_src)
            core_pkg::pcsrc_alu_out: pc_next = alu_out;  // target from decode
            core_pkg::pcsrc_jump:    pc_next = jump_target;
            default:                 pc_next = alu_result;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= `MIPS_RESET_PC;
        else if (pc_en)
            pc <= pc_next;
    end

    // data memory port
    assign mem.addr  = alu_out;  // base + imm from mem_addr state
    assign mem.wdata = b_reg;
    assign mem.read  = ctrl.mem_read;
    assign mem.write = ctrl.mem_write;

endmodule

// File: control/control_fsm.sv
module control_fsm (
    input  logic                 clk,
    input  logic                 rst,
    input  isa_pkg::instr_t      instr,
    output core_pkg::ctrl_word_t ctrl
);

    core_pkg::state_t state, state_nxt;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= core_pkg::st_fetch;
        else
            state <= state_nxt;
    end

    ////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////
    always_comb
    begin
        state_nxt = core_pkg::st_fetch;  // every path ends back in fetch
        case (state)
            core_pkg::st_fetch:     state_nxt = core_pkg::st_decode;
            core_pkg::st_decode:
            begin
                case (instr.opcode)
                    isa_pkg::op_lw,
                    isa_pkg::op_sw:    state_nxt = core_pkg::st_mem_addr;
                    isa_pkg::op_addiu: state_nxt = core_pkg::st_imm_exec;
                    isa_pkg::op_lui:   state_nxt = core_pkg::st_lui_exec;
                    isa_pkg::op_beq:   state_nxt = core_pkg::st_branch_eq;
                    isa_pkg::op_bne:   state_nxt = core_pkg::st_branch_ne;
                    isa_pkg::op_j:     state_nxt = core_pkg::st_jump;
                    isa_pkg::op_jal:   state_nxt = core_pkg::st_jal_link;
                    isa_pkg::op_rtype:
                        state_nxt = (instr.funct == isa_pkg::fn_sll) ?
                                    core_pkg::st_r_shift : core_pkg::st_r_exec;
                    default:           state_nxt = core_pkg::st_fetch;  // unknown op
                endcase
            end
            core_pkg::st_mem_addr:
                state_nxt = (instr.opcode == isa_pkg::op_lw) ?
                            core_pkg::st_load_read : core_pkg::st_store_write;
            core_pkg::st_load_read: state_nxt = core_pkg::st_load_wb;
            core_pkg::st_r_exec,
            core_pkg::st_r_shift:   state_nxt = core_pkg::st_r_wb;
            core_pkg::st_imm_exec,
            core_pkg::st_lui_exec:  state_nxt = core_pkg::st_imm_wb;
            core_pkg::st_jal_link:  state_nxt = core_pkg::st_jal_jump;
            default:                state_nxt = core_pkg::st_fetch;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // moore control word
    ////////////////////////////////////////////////////////////////////
    always_comb
    begin
        ctrl = '0;  // all strobes off, first select of each mux
        case (state)
            core_pkg::st_fetch:
            begin
                ctrl.mem_read = 1'b1;
                ctrl.ir_write = 1'b1;
                ctrl.pc_write = 1'b1;               // pc <= pc + 4
                ctrl.src_b    = core_pkg::srcb_four;
            end
            core_pkg::st_decode:
                ctrl.src_b = core_pkg::srcb_imm_sh;  // branch target into alu_out
            core_pkg::st_mem_addr,
            core_pkg::st_imm_exec:
            begin
                ctrl.src_a = core_pkg::srca_reg;
                ctrl.src_b = core_pkg::srcb_imm;
            end
            core_pkg::st_load_read:   ctrl.mem_read = 1'b1;
            core_pkg::st_load_wb:
            begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            core_pkg::st_store_write: ctrl.mem_write = 1'b1;
            core_pkg::st_r_exec:
            begin
                ctrl.src_a   = core_pkg::srca_reg;
                ctrl.alu_ctl = core_pkg::ctl_r_func;
            end
            core_pkg::st_r_shift:
            begin
                ctrl.src_a   = core_pkg::srca_shamt;  // shift amount on a
                ctrl.alu_ctl = core_pkg::ctl_r_func;
            end
            core_pkg::st_r_wb:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = core_pkg::dst_rd;
            end
            core_pkg::st_lui_exec:
            begin
                ctrl.alu_ctl = core_pkg::ctl_lui;
                ctrl.src_b   = core_pkg::srcb_imm;
            end
            core_pkg::st_imm_wb:      ctrl.reg_write = 1'b1;  // into rt
            core_pkg::st_branch_eq,
            core_pkg::st_branch_ne:
            begin
                ctrl.pc_write_beq = (state == core_pkg::st_branch_eq);
                ctrl.pc_write_bne = (state == core_pkg::st_branch_ne);
                ctrl.pc_src       = core_pkg::pcsrc_alu_out;
                ctrl.alu_ctl      = core_pkg::ctl_sub;  // compare a and b
                ctrl.src_a        = core_pkg::srca_reg;
            end
            core_pkg::st_jump:
            begin
                ctrl.pc_write = 1'b1;
                ctrl.pc_src   = core_pkg::pcsrc_jump;
            end
            core_pkg::st_jal_link:    ctrl.src_b = core_pkg::srcb_four;  // pc + 4 = addr + 8
            core_pkg::st_jal_jump:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = core_pkg::dst_ra;
                ctrl.pc_write  = 1'b1;
                ctrl.pc_src    = core_pkg::pcsrc_jump;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// File: rtl/perf_counters.sv
module perf_counters (
    input  logic                 clk,
    input  logic                 rst,
    input  core_pkg::ctrl_word_t ctrl,
    output core_pkg::perf_cnt_t  cnt
);

    logic not_fetch;  // ir_write marks the fetch cycle
    logic pc_wr_any;

    assign not_fetch = ~ctrl.ir_write;
    assign pc_wr_any = ctrl.pc_write | ctrl.pc_write_beq | ctrl.pc_write_bne;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt <= '0;
        end
        else
        begin
            cnt.cycles <= cnt.cycles + 1'b1;
            if (ctrl.ir_write)
                cnt.instrs <= cnt.instrs + 1'b1;
            if (pc_wr_any && not_fetch)     // taken or not
                cnt.branches <= cnt.branches + 1'b1;
            if (ctrl.mem_read && not_fetch)
                cnt.loads <= cnt.loads + 1'b1;
            if (ctrl.mem_write && not_fetch)
                cnt.stores <= cnt.stores + 1'b1;
        end
    end

endmodule

// File: rtl/mips_cpu.sv
`include "mips_cfg.svh"

module mips_cpu (
    input  logic                  clk,
    input  logic                  rst,
    // instruction side
    output logic [`MIPS_XLEN-1:0] pc,
    input  logic [`MIPS_XLEN-1:0] instruction,
    // data side
    output core_pkg::mem_req_t    mem,
    input  logic [`MIPS_XLEN-1:0] read_data,
    output core_pkg::perf_cnt_t   perf
);

    core_pkg::ctrl_word_t ctrl;   // fsm to datapath and counters
    isa_pkg::instr_t      instr;  // current ir back to the fsm

    control_fsm u_control (
        .clk   (clk),
        .rst   (rst),
        .instr (instr),
        .ctrl  (ctrl)
    );

    datapath u_datapath (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl),
        .instruction (instruction),
        .read_data   (read_data),
        .instr       (instr),
        .pc          (pc),
        .mem         (mem)
    );

    // counters only watch the control word
    perf_counters u_perf (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl),
        .cnt  (perf)
    );

endmodule

// File: tb/tb_isa_model.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

logic [31:0] prog [0:63];       // program, shared with the dut side
logic [31:0] ref_regs [0:31];
logic [31:0] ref_mem [0:15];
logic [31:0] ref_pc;
int unsigned ref_instrs, ref_loads, ref_stores, ref_branches, ref_cycles;
int unsigned loop_hits;         // executions of the final self-loop
logic [63:0] store_q [$];       // {addr, data} per expected store

// initial data word, built from the whole index
function automatic logic [31:0] data_fill(int unsigned i);
    return (i * 32'h0101_0101) ^ 32'ha5a5_0000;
endfunction

// r0..r7 or r31, all set up by the prologue
function automatic logic [4:0] rand_reg();
    int unsigned k;
    k = $urandom % 9;
    return (k == 8) ? 5'd31 : 5'(k);
endfunction

////////////////////////////////////////////////////////////////////////
// random program
////////////////////////////////////////////////////////////////////////
task automatic build_program();
    int unsigned kind;
    int unsigned tgt;
    logic [4:0]  r;
    for (int i = 0; i < 8; i++)
    begin
        r = (i == 7) ? 5'd31 : 5'(i + 1);
        prog[i] = {isa_pkg::op_addiu, 5'd0, r, 16'($urandom)};  // known start values
    end
    for (int i = 8; i < 63; i++)
    begin
        kind = $urandom % 12;
        tgt  = i + 1 + ($urandom % (63 - i));  // forward only, word 63 at most
        case (kind)
            0: prog[i] = {6'd0, rand_reg(), rand_reg(), rand_reg(), 5'd0, isa_pkg::fn_addu};
            1: prog[i] = {6'd0, rand_reg(), rand_reg(), rand_reg(), 5'd0, isa_pkg::fn_or};
            2: prog[i] = {6'd0, rand_reg(), rand_reg(), rand_reg(), 5'd0, isa_pkg::fn_slt};
            3: prog[i] = {6'd0, 5'd0, rand_reg(), rand_reg(), 5'($urandom), isa_pkg::fn_sll};
            4: prog[i] = {isa_pkg::op_addiu, rand_reg(), rand_reg(), 16'($urandom)};
            5: prog[i] = {isa_pkg::op_lui, 5'd0, rand_reg(), 16'($urandom)};
            6: prog[i] = {isa_pkg::op_lw, 5'd0, rand_reg(), 16'(4 * ($urandom % 16))};
            7: prog[i] = {isa_pkg::op_sw, 5'd0, rand_reg(), 16'(4 * ($urandom % 16))};
            8: prog[i] = {isa_pkg::op_beq, rand_reg(), rand_reg(), 16'(tgt - i - 1)};
            9: prog[i] = {isa_pkg::op_bne, rand_reg(), rand_reg(), 16'(tgt - i - 1)};
            10: prog[i] = {isa_pkg::op_j, 26'(tgt)};
            default: prog[i] = {isa_pkg::op_jal, 26'(tgt)};
        endcase
    end
    prog[63] = {isa_pkg::op_j, 26'd63};  // self-loop
endtask

////////////////////////////////////////////////////////////////////////
// one instruction of the reference model
////////////////////////////////////////////////////////////////////////
task automatic step_reference();
    logic [31:0] w, a, b, imm, pc4;
    logic [5:0]  op;
    logic [4:0]  rt, rd;
    w   = prog[ref_pc[7:2]];
    op  = w[31:26];
    a   = ref_regs[w[25:21]];
    b   = ref_regs[w[20:16]];
    rt  = w[20:16];
    rd  = w[15:11];
    imm = {{16{w[15]}}, w[15:0]};
    pc4 = ref_pc + 32'd4;
    if (ref_pc[7:2] == 6'd63)
        loop_hits++;
    ref_pc = pc4;
    ref_instrs++;
    case (op)
        isa_pkg::op_rtype:
        begin
            ref_cycles += 4;
            case (w[5:0])
                isa_pkg::fn_addu: ref_regs[rd] = a + b;
                isa_pkg::fn_or:   ref_regs[rd] = a | b;
                isa_pkg::fn_slt:  ref_regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default:          ref_regs[rd] = b << w[10:6];  // sll
            endcase
        end
        isa_pkg::op_addiu:
        begin
            ref_regs[rt] = a + imm;
            ref_cycles += 4;
        end
        isa_pkg::op_lui:
        begin
            ref_regs[rt] = {w[15:0], 16'h0000};
            ref_cycles += 4;
        end
        isa_pkg::op_lw:
        begin
            ref_regs[rt] = ref_mem[imm[5:2]];  // base is r0
            ref_loads++;
            ref_cycles += 5;
        end
        isa_pkg::op_sw:
        begin
            ref_mem[imm[5:2]] = b;
            store_q.push_back({imm, b});
            ref_stores++;
            ref_cycles += 4;
        end
        isa_pkg::op_beq, isa_pkg::op_bne:
        begin
            if ((a == b) == (op == isa_pkg::op_beq))
                ref_pc = pc4 + (imm << 2);
            ref_branches++;
            ref_cycles += 3;
        end
        isa_pkg::op_j, isa_pkg::op_jal:
        begin
            if (op == isa_pkg::op_jal)
                ref_regs[31] = pc4 + 32'd4;  // link is addr + 8
            ref_pc = {pc4[31:28], w[25:0], 2'b00};
            ref_branches++;
            ref_cycles += (op == isa_pkg::op_jal) ? 4 : 3;
        end
        default: ref_cycles += 2;  // unknown op, fetch and decode only
    endcase
    ref_regs[0] = 32'd0;
endtask

`endif

// File: tb/tb_mips_cpu.sv
`include "mips_cfg.svh"

module tb_mips_cpu;

    logic                  clk;
    logic                  rst;
    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] instruction;
    logic [`MIPS_XLEN-1:0] read_data;
    core_pkg::mem_req_t    mem;
    core_pkg::perf_cnt_t   perf;

    logic [31:0] dmem [0:15];   // data memory seen by the dut
    int unsigned errors;
    int unsigned timeouts;
    int unsigned mem_reads;     // read strobe cycles, fetch included
    logic [31:0] prev_pc;       // pc at the previous falling edge
    logic [31:0] last_instrs;

    `include "tb_isa_model.svh"

    mips_cpu dut (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .instruction (instruction),
        .mem         (mem),
        .read_data   (read_data),
        .perf        (perf)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // both memories answer 10 units after the edge
    always @(posedge clk)
    begin
        #10;
        instruction = prog[pc[7:2]];
        read_data   = dmem[mem.addr[5:2]];
    end

    ////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("ERR %s: got %h expected %h", name, got, exp);
    endtask

    task automatic count_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic compare_store();
        logic [63:0] exp;
        if (mem.write)
        begin
            assert (mem.addr < 32'd64) else count_failure("store outside the data region");
            assert (store_q.size() != 0) else count_failure("store that the model did not make");
            if (store_q.size() != 0)
            begin
                exp = store_q.pop_front();
                assert (mem.addr == exp[63:32])
                    else report_mismatch("mem.addr", mem.addr, exp[63:32]);
                assert (mem.wdata == exp[31:0])
                    else report_mismatch("mem.wdata", mem.wdata, exp[31:0]);
            end
            dmem[mem.addr[5:2]] = mem.wdata;
        end
    endtask

    // pc of the fetch just seen, cycle count so far
    task automatic verify_fetch();
        last_instrs = perf.instrs;
        assert (prev_pc == ref_pc) else report_mismatch("pc", prev_pc, ref_pc);
        assert (perf.cycles == ref_cycles + 1) else report_mismatch("perf.cycles", perf.cycles,
                                                                    ref_cycles + 1);
    endtask

    task automatic match_counters();
        assert (perf.instrs == ref_instrs + 1) else report_mismatch("perf.instrs", perf.instrs,
                                                                    ref_instrs + 1);
        assert (perf.loads == ref_loads) else report_mismatch("perf.loads", perf.loads, ref_loads);
        assert (perf.stores == ref_stores) else report_mismatch("perf.stores", perf.stores,
                                                                ref_stores);
        assert (perf.branches == ref_branches) else report_mismatch("perf.branches", perf.branches,
                                                                    ref_branches);
        // one read per fetch and one per load
        assert (mem_reads == ref_instrs + 1 + ref_loads)
            else report_mismatch("mem.read cycles", mem_reads, ref_instrs + 1 + ref_loads);
        assert (store_q.size() == 0)
            else count_failure("a store of the model never reached data memory");
    endtask

    ////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////
    initial
    begin : main
        int unsigned spins;
        int unsigned steps;
        logic        fetched;
        logic        finished;
        void'($urandom(32'h2f));
        rst         = 1'b1;
        instruction = '0;
        read_data   = '0;
        errors      = 0;
        timeouts    = 0;
        mem_reads   = 0;
        for (int i = 0; i < 16; i++)
        begin
            dmem[i]    = data_fill(i);
            ref_mem[i] = data_fill(i);
        end
        for (int i = 0; i < 32; i++)
            ref_regs[i] = 32'd0;
        ref_pc       = `MIPS_RESET_PC;
        ref_instrs   = 0;
        ref_loads    = 0;
        ref_stores   = 0;
        ref_branches = 0;
        ref_cycles   = 0;
        loop_hits    = 0;
        build_program();
        repeat (4) @(posedge clk);
        #10 rst = 1'b0;
        last_instrs = '0;
        prev_pc     = '0;
        finished    = 1'b0;
        steps       = 0;
        while (!finished && timeouts == 0 && steps < 200)
        begin
            spins   = 0;
            fetched = 1'b0;
            while (!fetched && spins < 10)  // longest instruction is 5 cycles
            begin
                @(negedge clk);
                spins++;
                compare_store();
                if (mem.read)
                    mem_reads++;
                fetched = (perf.instrs != last_instrs);  // counter lags fetch by one
                if (fetched)
                    verify_fetch();
                prev_pc = pc;
            end
            if (!fetched)
            begin
                timeouts++;
                $display("timeout waiting for the fetch of instruction %0d", ref_instrs + 1);
            end
            else if (loop_hits == 11)  // self-loop plus ten more
            begin
                match_counters();
                finished = 1'b1;
            end
            else
            begin
                step_reference();
                steps++;
            end
        end
        if (!finished && timeouts == 0)
            count_failure("the program never reached its final loop");
        for (int i = 0; i < 16; i++)
            assert (dmem[i] === ref_mem[i]) else report_mismatch($sformatf("dmem[%0d]", i),
                                                                 dmem[i], ref_mem[i]);
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: mips_multicycle.f
+incdir+common
+incdir+tb
common/isa_pkg.sv
common/core_pkg.sv
datapath/reg_file.sv
datapath/alu.sv
datapath/datapath.sv
control/control_fsm.sv
rtl/perf_counters.sv
rtl/mips_cpu.sv
tb/tb_mips_cpu.sv
